/* list.f */
+incdir+source
source/cc_pkg.sv
source/request_fifo.sv
source/io_map_buffer.sv
source/snoop_match.sv
source/way_counter.sv
source/cache_ctrl_fsm.sv
source/cache_controller_top.sv
test/tb_clock.sv
test/cache_controller_tb.sv

/* test/cache_controller_tb.sv */
// Directed testbench for the cache controller, with tag array, memory and core models
`timescale 1ns/1ps
`include "cc_defs.svh"

module cache_controller_tb;

	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic load_valid;
	cc_pkg::thread_id_t load_thread;
	cc_pkg::address_t load_address;
	logic load_dequeue;
	logic flush_valid;
	cc_pkg::address_t flush_address;
	cc_pkg::line_t flush_line;
	cc_pkg::dirty_mask_t flush_dirty_mask;
	logic flush_dequeue;
	logic io_valid;
	cc_pkg::thread_id_t io_thread;
	cc_pkg::io_op_t io_op;
	cc_pkg::address_t io_address;
	cc_pkg::reg_t io_data;
	logic io_available;
	logic io_resp_valid;
	cc_pkg::thread_id_t io_resp_thread;
	cc_pkg::reg_t io_resp_data;
	logic io_resp_consumed;
	logic snoop_tag_valid;
	cc_pkg::set_t snoop_tag_set;
	cc_pkg::tag_t [`CC_WAYS-1:0] snoop_tag;
	cc_pkg::privileges_t [`CC_WAYS-1:0] snoop_privileges;
	logic mem_available;
	logic mem_read;
	logic mem_write;
	cc_pkg::address_t mem_address;
	cc_pkg::line_t mem_data;
	cc_pkg::dirty_mask_t mem_mask;
	logic mem_resp_valid;
	cc_pkg::line_t mem_resp_data;
	logic update_valid;
	cc_pkg::way_idx_t update_way;
	cc_pkg::address_t update_address;
	cc_pkg::privileges_t update_privileges;
	cc_pkg::line_t update_line;
	cc_pkg::cc_command_t update_command;
	logic wakeup;
	cc_pkg::thread_id_t wakeup_thread;

	integer seed = 64630;
	int failures = 0;
	logic mem_stall;
	int resp_delay;
	cc_pkg::address_t read_address;

	// Contents of the load/store unit tag array
	cc_pkg::tag_t tag_store [`CC_SETS][`CC_WAYS];
	cc_pkg::privileges_t priv_store [`CC_SETS][`CC_WAYS];

	// Every memory request in issue order
	cc_pkg::address_t req_address [$];
	logic req_write [$];
	cc_pkg::line_t req_data [$];
	cc_pkg::dirty_mask_t req_mask [$];

	tb_clock tb_clock_i (.clk(clk));

	cache_controller_top cache_controller_top_i (.*);

	function automatic cc_pkg::address_t make_address(input cc_pkg::tag_t tag,
		input cc_pkg::set_t set, input logic [`CC_OFFSET_W-1:0] offset);
		return {tag, set, offset};
	endfunction

	// Memory contents, every word depends on the whole address
	function automatic cc_pkg::line_t line_pattern(input cc_pkg::address_t address);
		cc_pkg::line_t line;
		for (int i = 0; i < `CC_LINE_W / 32; i++)
			line[i*32 +: 32] = {address[15:0] ^ 16'ha5c3, address[31:16]} + 32'(i) * 32'h0101_0011;
		return line;
	endfunction

	// Tag array answers a snoop one cycle later and installs updated lines
	always @(posedge clk) begin
		if (snoop_tag_valid === 1'b1) begin
			for (int w = 0; w < `CC_WAYS; w++) begin
				snoop_tag[w] <= tag_store[snoop_tag_set][w];
				snoop_privileges[w] <= priv_store[snoop_tag_set][w];
			end
		end
		if (update_valid === 1'b1) begin
			tag_store[update_address[`CC_OFFSET_W +: `CC_INDEX_W]][update_way] =
				update_address[`CC_ADDR_W-1 -: `CC_TAG_W];
			priv_store[update_address[`CC_OFFSET_W +: `CC_INDEX_W]][update_way] = update_privileges;
		end
	end

	// Memory with random availability and random read latency
	always @(posedge clk) begin
		mem_available <= !mem_stall && (($random(seed) & 3) != 0);
		mem_resp_valid <= 1'b0;
		if (resp_delay > 0) begin
			if (resp_delay == 1) begin
				mem_resp_valid <= 1'b1;
				mem_resp_data <= line_pattern(read_address);
			end
			resp_delay = resp_delay - 1;
		end
		if (mem_read === 1'b1 || mem_write === 1'b1) begin
			req_address.push_back(mem_address);
			req_write.push_back(mem_write);
			req_data.push_back(mem_data);
			req_mask.push_back(mem_mask);
		end
		if (mem_read === 1'b1) begin
			read_address = mem_address;
			resp_delay = 1 + ($random(seed) & 3);
		end
	end

	// The core withdraws a request once it is dequeued
	always @(posedge clk) begin
		if (load_dequeue === 1'b1)
			load_valid <= 1'b0;
		if (flush_dequeue === 1'b1)
			flush_valid <= 1'b0;
	end

	task automatic stop_with_error(input string text);
		failures++;
		$display("%s", text);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_address(input string name, input cc_pkg::address_t got,
		input cc_pkg::address_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_line(input string name, input cc_pkg::line_t got, input cc_pkg::line_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_mask(input string name, input cc_pkg::dirty_mask_t got,
		input cc_pkg::dirty_mask_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_way(input string name, input cc_pkg::way_idx_t got,
		input cc_pkg::way_idx_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_privileges(input string name, input cc_pkg::privileges_t got,
		input cc_pkg::privileges_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_command(input string name, input cc_pkg::cc_command_t got,
		input cc_pkg::cc_command_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_thread(input string name, input cc_pkg::thread_id_t got,
		input cc_pkg::thread_id_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_reg(input string name, input cc_pkg::reg_t got, input cc_pkg::reg_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic expect_request_count(input int exp);
		if (req_address.size() != exp)
			stop_with_error($sformatf("Memory saw %0d requests where %0d were expected",
				req_address.size(), exp));
	endtask

	// Checks one logged memory request against its expected address and direction
	task automatic check_request(input int n, input cc_pkg::address_t address, input logic write);
		check_address("mem_address", req_address[n], address);
		check_flag("mem_write", req_write[n], write);
	endtask

	task automatic await_update();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (update_valid !== 1'b1 && cycles < WAIT_LIMIT);
		if (update_valid !== 1'b1)
			stop_with_error("Timed out waiting for the line update of a load miss");
	endtask

	task automatic await_load_dequeue();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (load_dequeue !== 1'b1 && cycles < WAIT_LIMIT);
		if (load_dequeue !== 1'b1)
			stop_with_error("Timed out waiting for the load to be dequeued");
	endtask

	task automatic await_flush_dequeue();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (flush_dequeue !== 1'b1 && cycles < WAIT_LIMIT);
		if (flush_dequeue !== 1'b1)
			stop_with_error("Timed out waiting for the flush to be dequeued");
	endtask

	task automatic await_io_response();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (io_resp_valid !== 1'b1 && cycles < WAIT_LIMIT);
		if (io_resp_valid !== 1'b1)
			stop_with_error("Timed out waiting for the IO read response");
	endtask

	task automatic await_io_room();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (io_available !== 1'b1 && cycles < WAIT_LIMIT);
		if (io_available !== 1'b1)
			stop_with_error("Timed out waiting for room in the IO request buffer");
	endtask

	task automatic await_mem_requests(input int total);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (req_address.size() < total && cycles < WAIT_LIMIT);
		if (req_address.size() < total)
			stop_with_error("Timed out waiting for memory requests to be issued");
	endtask

	task automatic issue_load(input cc_pkg::thread_id_t thread, input cc_pkg::address_t address);
		@(posedge clk);
		load_valid <= 1'b1;
		load_thread <= thread;
		load_address <= address;
	endtask

	task automatic issue_io(input cc_pkg::io_op_t op, input cc_pkg::thread_id_t thread,
		input cc_pkg::address_t address, input cc_pkg::reg_t data);
		await_io_room();
		io_valid <= 1'b1;
		io_op <= op;
		io_thread <= thread;
		io_address <= address;
		io_data <= data;
		@(posedge clk);
		io_valid <= 1'b0;
	endtask

	task automatic check_reset_values();
		@(posedge clk);
		check_flag("mem_read", mem_read, 1'b0);
		check_flag("mem_write", mem_write, 1'b0);
		check_flag("update_valid", update_valid, 1'b0);
		check_flag("wakeup", wakeup, 1'b0);
		check_flag("load_dequeue", load_dequeue, 1'b0);
		check_flag("flush_dequeue", flush_dequeue, 1'b0);
		check_flag("io_resp_valid", io_resp_valid, 1'b0);
		check_flag("io_available", io_available, 1'b1);
	endtask

	// Miss into an empty set installs into way 0
	task automatic load_miss_free_way();
		cc_pkg::address_t address;
		int start;
		address = make_address(21'h1a2b3, 5'd1, 6'h08);
		start = req_address.size();
		issue_load(2'd1, address);
		await_update();
		check_way("update_way", update_way, 2'd0);
		check_address("update_address", update_address, address);
		check_privileges("update_privileges", update_privileges, 2'b11);
		check_command("update_command", update_command, cc_pkg::CC_UPDATE_INFO_DATA);
		check_line("update_line", update_line, line_pattern(address));
		check_flag("wakeup", wakeup, 1'b1);
		check_thread("wakeup_thread", wakeup_thread, 2'd1);
		check_flag("load_dequeue", load_dequeue, 1'b1);
		expect_request_count(start + 1);
		check_request(start, address, 1'b0);
	endtask

	// Line installed by the previous miss is now present in the tag array
	task automatic load_snoop_hit();
		cc_pkg::address_t address;
		int start;
		address = make_address(21'h1a2b3, 5'd1, 6'h10);
		start = req_address.size();
		issue_load(2'd2, address);
		await_load_dequeue();
		check_flag("wakeup", wakeup, 1'b1);
		check_thread("wakeup_thread", wakeup_thread, 2'd2);
		check_flag("update_valid", update_valid, 1'b0);
		@(posedge clk);
		expect_request_count(start);
	endtask

	task automatic full_set_replacement();
		cc_pkg::address_t address;
		for (int w = 0; w < `CC_WAYS; w++) begin
			tag_store[1][w] = cc_pkg::tag_t'(21'h00100 + w);
			priv_store[1][w] = 2'b10;
		end
		for (int i = 0; i < `CC_WAYS; i++) begin
			address = make_address(cc_pkg::tag_t'(21'h0a000 + i), 5'd1, 6'h00);
			issue_load(cc_pkg::thread_id_t'(i), address);
			await_update();
			check_way("update_way", update_way, cc_pkg::way_idx_t'((i + 1) % `CC_WAYS));
			check_command("update_command", update_command, cc_pkg::CC_REPLACEMENT);
			check_line("update_line", update_line, line_pattern(address));
			check_thread("wakeup_thread", wakeup_thread, cc_pkg::thread_id_t'(i));
		end
	endtask

	task automatic flush_hit_and_miss();
		cc_pkg::address_t address;
		cc_pkg::line_t line;
		cc_pkg::dirty_mask_t mask;
		int start;
		address = make_address(21'h0f00d, 5'd2, 6'h00);
		mask = 64'h00ff_0000_f0f0_000f;
		for (int i = 0; i < `CC_LINE_W / 32; i++)
			line[i*32 +: 32] = $random(seed);
		tag_store[2][2] = 21'h0f00d;
		priv_store[2][2] = 2'b11;
		start = req_address.size();
		@(posedge clk);
		flush_valid <= 1'b1;
		flush_address <= address;
		flush_line <= line;
		flush_dirty_mask <= mask;
		await_flush_dequeue();
		@(posedge clk);
		expect_request_count(start + 1);
		check_request(start, address, 1'b1);
		check_line("mem_data", req_data[start], line);
		check_mask("mem_mask", req_mask[start], mask);
		// Set 3 holds nothing, so this flush must not reach memory
		@(posedge clk);
		flush_valid <= 1'b1;
		flush_address <= make_address(21'h0f00e, 5'd3, 6'h00);
		await_flush_dequeue();
		@(posedge clk);
		expect_request_count(start + 1);
	endtask

	task automatic io_write_then_read();
		cc_pkg::line_t line;
		int start;
		start = req_address.size();
		issue_io(1'b1, 2'd3, 32'h8000_0010, 32'h1234_5678);
		await_mem_requests(start + 1);
		check_request(start, 32'h8000_0010, 1'b1);
		line = req_data[start];
		check_reg("mem_data", line[`CC_REG_W-1:0], 32'h1234_5678);
		check_mask("mem_mask", req_mask[start], 64'h0000_0000_0000_000f);
		issue_io(1'b0, 2'd2, 32'h8000_0044, 32'h0);
		await_io_response();
		line = line_pattern(32'h8000_0044);
		check_thread("io_resp_thread", io_resp_thread, 2'd2);
		check_reg("io_resp_data", io_resp_data, line[`CC_REG_W-1:0]);
		check_request(start + 1, 32'h8000_0044, 1'b0);
		io_resp_consumed <= 1'b1;
		@(posedge clk);
		io_resp_consumed <= 1'b0;
		@(posedge clk);
		check_flag("io_resp_valid", io_resp_valid, 1'b0);
	endtask

	// Requests pile up in the IO buffer while memory refuses them
	task automatic io_backpressure();
		int start;
		start = req_address.size();
		mem_stall = 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < `CC_IO_ALMOST_FULL; i++)
			issue_io(1'b1, 2'd1, 32'h8000_0100 + 32'(i) * 4, 32'hc0de_0000 + 32'(i));
		@(posedge clk);
		check_flag("io_available", io_available, 1'b0);
		mem_stall = 1'b0;
		await_mem_requests(start + `CC_IO_ALMOST_FULL);
		for (int i = 0; i < `CC_IO_ALMOST_FULL; i++)
			check_request(start + i, 32'h8000_0100 + 32'(i) * 4, 1'b1);
		await_io_room();
	endtask

	task automatic priority_order();
		cc_pkg::address_t flush_target;
		cc_pkg::address_t load_target;
		int start;
		flush_target = make_address(21'h0beef, 5'd4, 6'h00);
		load_target = make_address(21'h0cafe, 5'd5, 6'h00);
		tag_store[4][0] = 21'h0beef;
		priv_store[4][0] = 2'b11;
		start = req_address.size();
		issue_io(1'b1, 2'd0, 32'h9000_0000, 32'h5555_aaaa);
		flush_valid <= 1'b1;
		flush_address <= flush_target;
		flush_line <= line_pattern(32'h1357_9bdf);
		flush_dirty_mask <= '1;
		load_valid <= 1'b1;
		load_thread <= 2'd3;
		load_address <= load_target;
		await_mem_requests(start + 3);
		check_request(start, flush_target, 1'b1);
		check_request(start + 1, load_target, 1'b0);
		check_request(start + 2, 32'h9000_0000, 1'b1);
	endtask

	initial begin
		reset = 1'b1;
		load_valid = 1'b0;
		load_thread = '0;
		load_address = '0;
		flush_valid = 1'b0;
		flush_address = '0;
		flush_line = '0;
		flush_dirty_mask = '0;
		io_valid = 1'b0;
		io_thread = '0;
		io_op = 1'b0;
		io_address = '0;
		io_data = '0;
		io_resp_consumed = 1'b0;
		snoop_tag = '0;
		snoop_privileges = '0;
		mem_available = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		mem_stall = 1'b0;
		resp_delay = 0;
		read_address = '0;
		for (int s = 0; s < `CC_SETS; s++) begin
			for (int w = 0; w < `CC_WAYS; w++) begin
				tag_store[s][w] = '0;
				priv_store[s][w] = 2'b00;
			end
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		check_reset_values();
		load_miss_free_way();
		load_snoop_hit();
		full_set_replacement();
		flush_hit_and_miss();
		io_write_then_read();
		io_backpressure();
		priority_order();

		repeat (4) @(posedge clk);
		if (failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* test/tb_clock.sv */
// Free-running 8 ns clock for the cache controller testbench
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

endmodule

/* source/cache_controller_top.sv */
// Top level of the L1 data cache controller, connecting the FSM with its datapath blocks
`timescale 1ns/1ps
`include "cc_defs.svh"

module cache_controller_top (
	input logic clk,
	input logic reset,
	input logic load_valid,
	input cc_pkg::thread_id_t load_thread,
	input cc_pkg::address_t load_address,
	output logic load_dequeue,
	input logic flush_valid,
	input cc_pkg::address_t flush_address,
	input cc_pkg::line_t flush_line,
	input cc_pkg::dirty_mask_t flush_dirty_mask,
	output logic flush_dequeue,
	input logic io_valid,
	input cc_pkg::thread_id_t io_thread,
	input cc_pkg::io_op_t io_op,
	input cc_pkg::address_t io_address,
	input cc_pkg::reg_t io_data,
	output logic io_available,
	output logic io_resp_valid,
	output cc_pkg::thread_id_t io_resp_thread,
	output cc_pkg::reg_t io_resp_data,
	input logic io_resp_consumed,
	output logic snoop_tag_valid,
	output cc_pkg::set_t snoop_tag_set,
	input cc_pkg::tag_t [`CC_WAYS-1:0] snoop_tag,
	input cc_pkg::privileges_t [`CC_WAYS-1:0] snoop_privileges,
	input logic mem_available,
	output logic mem_read,
	output logic mem_write,
	output cc_pkg::address_t mem_address,
	output cc_pkg::line_t mem_data,
	output cc_pkg::dirty_mask_t mem_mask,
	input logic mem_resp_valid,
	input cc_pkg::line_t mem_resp_data,
	output logic update_valid,
	output cc_pkg::way_idx_t update_way,
	output cc_pkg::address_t update_address,
	output cc_pkg::privileges_t update_privileges,
	output cc_pkg::line_t update_line,
	output cc_pkg::cc_command_t update_command,
	output logic wakeup,
	output cc_pkg::thread_id_t wakeup_thread
);

	logic io_pending;
	cc_pkg::io_entry_t io_request;
	logic io_request_done;
	logic io_resp_push;
	cc_pkg::tag_t granted_tag;
	logic hit;
	logic capture;
	logic full_reg;
	cc_pkg::way_idx_t victim_way;
	logic advance;
	cc_pkg::set_t counter_set;

	cache_ctrl_fsm cache_ctrl_fsm_i (
		.clk(clk),
		.reset(reset),
		.load_valid(load_valid),
		.load_thread(load_thread),
		.load_address(load_address),
		.load_dequeue(load_dequeue),
		.flush_valid(flush_valid),
		.flush_address(flush_address),
		.flush_line(flush_line),
		.flush_dirty_mask(flush_dirty_mask),
		.flush_dequeue(flush_dequeue),
		.pending(io_pending),
		.request(io_request),
		.request_done(io_request_done),
		.resp_push(io_resp_push),
		.snoop_tag_valid(snoop_tag_valid),
		.snoop_tag_set(snoop_tag_set),
		.granted_tag(granted_tag),
		.hit(hit),
		.capture(capture),
		.full_reg(full_reg),
		.victim_way(victim_way),
		.advance(advance),
		.counter_set(counter_set),
		.mem_available(mem_available),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_data(mem_data),
		.mem_mask(mem_mask),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data),
		.update_valid(update_valid),
		.update_way(update_way),
		.update_address(update_address),
		.update_privileges(update_privileges),
		.update_line(update_line),
		.update_command(update_command),
		.wakeup(wakeup),
		.wakeup_thread(wakeup_thread)
	);

	io_map_buffer io_map_buffer_i (
		.clk(clk),
		.reset(reset),
		.io_valid(io_valid),
		.io_thread(io_thread),
		.io_op(io_op),
		.io_address(io_address),
		.io_data(io_data),
		.io_available(io_available),
		.pending(io_pending),
		.request(io_request),
		.request_done(io_request_done),
		.resp_push(io_resp_push),
		.mem_resp_data(mem_resp_data),
		.io_resp_valid(io_resp_valid),
		.io_resp_thread(io_resp_thread),
		.io_resp_data(io_resp_data),
		.io_resp_consumed(io_resp_consumed)
	);

	// Matched way is not needed since a hit never installs a line
	snoop_match snoop_match_i (
		.clk(clk),
		.reset(reset),
		.snoop_tag(snoop_tag),
		.snoop_privileges(snoop_privileges),
		.granted_tag(granted_tag),
		.hit(hit),
		.full_reg(full_reg),
		.matched_way_reg(),
		.capture(capture)
	);

	way_counter way_counter_i (
		.clk(clk),
		.reset(reset),
		.set(counter_set),
		.advance(advance),
		.victim_way(victim_way)
	);

endmodule

/* source/cache_ctrl_fsm.sv */
// Controller FSM that serializes flush, load miss and IO requests toward memory
`timescale 1ns/1ps
`include "cc_defs.svh"

module cache_ctrl_fsm (
	input logic clk,
	input logic reset,
	// Core requests
	input logic load_valid,
	input cc_pkg::thread_id_t load_thread,
	input cc_pkg::address_t load_address,
	output logic load_dequeue,
	input logic flush_valid,
	input cc_pkg::address_t flush_address,
	input cc_pkg::line_t flush_line,
	input cc_pkg::dirty_mask_t flush_dirty_mask,
	output logic flush_dequeue,
	// IO buffer
	input logic pending,
	input cc_pkg::io_entry_t request,
	output logic request_done,
	output logic resp_push,
	// Snoop
	output logic snoop_tag_valid,
	output cc_pkg::set_t snoop_tag_set,
	output cc_pkg::tag_t granted_tag,
	input logic hit,
	output logic capture,
	input logic full_reg,
	// Victim selection
	input cc_pkg::way_idx_t victim_way,
	output logic advance,
	output cc_pkg::set_t counter_set,
	// Memory
	input logic mem_available,
	output logic mem_read,
	output logic mem_write,
	output cc_pkg::address_t mem_address,
	output cc_pkg::line_t mem_data,
	output cc_pkg::dirty_mask_t mem_mask,
	input logic mem_resp_valid,
	input cc_pkg::line_t mem_resp_data,
	// Load/store unit update
	output logic update_valid,
	output cc_pkg::way_idx_t update_way,
	output cc_pkg::address_t update_address,
	output cc_pkg::privileges_t update_privileges,
	output cc_pkg::line_t update_line,
	output cc_pkg::cc_command_t update_command,
	output logic wakeup,
	output cc_pkg::thread_id_t wakeup_thread
);

	cc_pkg::cc_state_t state;

	logic grant_open;
	logic grant_flush;
	logic grant_load;
	logic grant_io;
	logic grant;
	logic execute;

	logic granted_flush;
	logic granted_load;
	logic granted_io;
	logic granted_read;
	logic need_snoop;
	logic need_hit;
	cc_pkg::address_t granted_address;
	cc_pkg::thread_id_t granted_thread;
	cc_pkg::line_t granted_line;
	cc_pkg::dirty_mask_t granted_mask;

	// No new grant while the previous request is still being dequeued
	assign grant_open = (state == cc_pkg::IDLE) && !(load_dequeue || flush_dequeue || request_done);
	assign grant_flush = grant_open && flush_valid;
	assign grant_load = grant_open && !flush_valid && load_valid;
	assign grant_io = grant_open && !flush_valid && !load_valid && pending;
	assign grant = grant_flush || grant_load || grant_io;

	// Loads and flushes look at the tag array first, IO goes straight to memory
	assign snoop_tag_valid = grant_flush || grant_load;
	assign snoop_tag_set = flush_valid ? flush_address[`CC_OFFSET_W +: `CC_INDEX_W]
		: load_address[`CC_OFFSET_W +: `CC_INDEX_W];

	assign granted_tag = granted_address[`CC_ADDR_W-1 -: `CC_TAG_W];
	assign counter_set = granted_address[`CC_OFFSET_W +: `CC_INDEX_W];
	assign capture = (state == cc_pkg::SEND_REQ) && need_snoop;

	// Flush needs a hit, a load needs a miss since the line may have arrived meanwhile
	assign execute = !need_snoop || (hit == need_hit);

	assign mem_address = granted_address;
	assign mem_data = granted_line;
	assign mem_mask = granted_mask;
	assign wakeup_thread = granted_thread;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cc_pkg::IDLE;
			granted_flush <= 1'b0;
			granted_load <= 1'b0;
			granted_io <= 1'b0;
			need_snoop <= 1'b0;
			need_hit <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			update_valid <= 1'b0;
			wakeup <= 1'b0;
			load_dequeue <= 1'b0;
			flush_dequeue <= 1'b0;
			request_done <= 1'b0;
			resp_push <= 1'b0;
			advance <= 1'b0;
		end else begin
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			update_valid <= 1'b0;
			wakeup <= 1'b0;
			load_dequeue <= 1'b0;
			flush_dequeue <= 1'b0;
			request_done <= 1'b0;
			resp_push <= 1'b0;
			advance <= 1'b0;

			case (state)
				cc_pkg::IDLE: begin
					if (grant) begin
						state <= cc_pkg::SEND_REQ;
						granted_flush <= grant_flush;
						granted_load <= grant_load;
						granted_io <= grant_io;
						need_snoop <= grant_flush || grant_load;
						need_hit <= grant_flush;
					end
				end

				cc_pkg::SEND_REQ: begin
					if (!execute) begin
						// Flush miss or load hit, nothing to do in memory
						state <= cc_pkg::IDLE;
						flush_dequeue <= granted_flush;
						load_dequeue <= granted_load;
						wakeup <= granted_load;
					end else if (mem_available) begin
						mem_read <= granted_read;
						mem_write <= !granted_read;
						if (granted_read) begin
							state <= cc_pkg::WAIT_RESP;
						end else begin
							state <= cc_pkg::IDLE;
							flush_dequeue <= granted_flush;
							request_done <= granted_io;
						end
					end else begin
						// Snoop outcome is kept while memory stalls
						need_snoop <= 1'b0;
					end
				end

				cc_pkg::WAIT_RESP: begin
					if (mem_resp_valid) begin
						state <= cc_pkg::IDLE;
						update_valid <= granted_load;
						wakeup <= granted_load;
						load_dequeue <= granted_load;
						advance <= granted_load;
						request_done <= granted_io;
						resp_push <= granted_io;
					end
				end

				default: state <= cc_pkg::IDLE;
			endcase
		end
	end

	// Request payload and update data
	always_ff @(posedge clk) begin
		if (grant) begin
			if (grant_flush) begin
				granted_address <= flush_address;
				granted_line <= flush_line;
				granted_mask <= flush_dirty_mask;
				granted_read <= 1'b0;
			end else if (grant_load) begin
				granted_address <= load_address;
				granted_thread <= load_thread;
				granted_read <= 1'b1;
			end else begin
				granted_address <= request.address;
				granted_read <= !request.op;
				// IO writes carry one register in the low bytes of the line
				granted_line <= cc_pkg::line_t'(request.data);
				granted_mask <= cc_pkg::dirty_mask_t'(4'hf);
			end
		end

		if (state == cc_pkg::WAIT_RESP && mem_resp_valid) begin
			update_way <= victim_way;
			update_address <= granted_address;
			update_privileges <= cc_pkg::privileges_t'(2'b11);
			update_line <= mem_resp_data;
			update_command <= full_reg ? cc_pkg::CC_REPLACEMENT : cc_pkg::CC_UPDATE_INFO_DATA;
		end
	end

	// One command at a time, and only after memory was available in SEND_REQ
	a_one_mem_cmd: assert property (@(posedge clk) disable iff (reset)
		(mem_read || mem_write) |-> !(mem_read && mem_write) && $past(mem_available)
			&& $past(state) == cc_pkg::SEND_REQ)
		else $error("memory command issued outside an available SEND_REQ cycle");

endmodule

/* source/way_counter.sv */
// Per-set rotating victim way selection for line installs
`timescale 1ns/1ps
`include "cc_defs.svh"

module way_counter (
	input logic clk,
	input logic reset,
	input cc_pkg::set_t set,
	input logic advance,
	output cc_pkg::way_idx_t victim_way
);

	cc_pkg::way_idx_t counters [`CC_SETS];

	assign victim_way = counters[set];

	// Move to the next way of the set once a line has been installed
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			counters <= '{default: '0};
		end else if (advance) begin
			if (counters[set] == cc_pkg::way_idx_t'(`CC_WAYS - 1))
				counters[set] <= '0;
			else
				counters[set] <= counters[set] + 1'b1;
		end
	end

endmodule

/* source/snoop_match.sv */
// Tag compare of the snooped set against the granted request, with hit and set-full detection
`timescale 1ns/1ps
`include "cc_defs.svh"

module snoop_match (
	input logic clk,
	input logic reset,
	input cc_pkg::tag_t [`CC_WAYS-1:0] snoop_tag,
	input cc_pkg::privileges_t [`CC_WAYS-1:0] snoop_privileges,
	input cc_pkg::tag_t granted_tag,
	output logic hit,
	output logic full_reg,
	output cc_pkg::way_idx_t matched_way_reg,
	input logic capture
);

	cc_pkg::way_mask_t busy;
	cc_pkg::way_mask_t match;
	cc_pkg::way_idx_t matched_way;

	// A way is valid when it holds any privilege
	for (genvar w = 0; w < `CC_WAYS; w++) begin : g_way
		assign busy[w] = |snoop_privileges[w];
		assign match[w] = busy[w] && (snoop_tag[w] == granted_tag);
	end

	assign hit = |match;

	// Lowest matching way wins
	always_comb begin
		matched_way = '0;
		for (int i = `CC_WAYS - 1; i >= 0; i--) begin
			if (match[i])
				matched_way = cc_pkg::way_idx_t'(i);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			full_reg <= 1'b0;
			matched_way_reg <= '0;
		end else if (capture) begin
			full_reg <= &busy;
			matched_way_reg <= matched_way;
		end
	end

	// The tag array never holds one line in two ways
	a_single_match: assert property (@(posedge clk) disable iff (reset) capture |-> $onehot0(match))
		else $error("snoop matched more than one way");

endmodule

/* source/io_map_buffer.sv */
// IO-mapped request and response buffering between the core and the controller FSM
`timescale 1ns/1ps
`include "cc_defs.svh"

module io_map_buffer (
	input logic clk,
	input logic reset,
	input logic io_valid,
	input cc_pkg::thread_id_t io_thread,
	input cc_pkg::io_op_t io_op,
	input cc_pkg::address_t io_address,
	input cc_pkg::reg_t io_data,
	output logic io_available,
	output logic pending,
	output cc_pkg::io_entry_t request,
	input logic request_done,
	input logic resp_push,
	input cc_pkg::line_t mem_resp_data,
	output logic io_resp_valid,
	output cc_pkg::thread_id_t io_resp_thread,
	output cc_pkg::reg_t io_resp_data,
	input logic io_resp_consumed
);

	localparam int RESP_W = $bits(cc_pkg::thread_id_t) + $bits(cc_pkg::reg_t);

	cc_pkg::io_entry_t req_in;
	logic req_empty;
	logic req_almost_full;
	cc_pkg::reg_t resp_word;
	logic [RESP_W-1:0] resp_out;
	logic resp_empty;

	assign req_in = '{thread: io_thread, op: io_op, address: io_address, data: io_data};

	request_fifo #(
		.WIDTH($bits(cc_pkg::io_entry_t)),
		.DEPTH(`CC_IO_FIFO_DEPTH),
		.ALMOST_FULL(`CC_IO_ALMOST_FULL)
	) request_fifo_i (
		.clk(clk),
		.reset(reset),
		.enqueue(io_valid),
		.value_in(req_in),
		.dequeue(request_done),
		.value_out(request),
		.empty(req_empty),
		.almost_full(req_almost_full)
	);

	// Memory data is sampled every cycle, so at resp_push it holds the word
	// that came with mem_resp_valid one cycle earlier
	always_ff @(posedge clk) begin
		resp_word <= mem_resp_data[`CC_REG_W-1:0];
	end

	// Head request is still the IO read while its response is pushed
	request_fifo #(
		.WIDTH(RESP_W),
		.DEPTH(`CC_IO_FIFO_DEPTH),
		.ALMOST_FULL(`CC_IO_FIFO_DEPTH)
	) response_fifo_i (
		.clk(clk),
		.reset(reset),
		.enqueue(resp_push),
		.value_in({request.thread, resp_word}),
		.dequeue(io_resp_consumed),
		.value_out(resp_out),
		.empty(resp_empty),
		.almost_full()
	);

	assign io_available = !req_almost_full;
	assign pending = !req_empty;
	assign io_resp_valid = !resp_empty;
	assign {io_resp_thread, io_resp_data} = resp_out;

	// The core may only enqueue while the buffer advertises room
	a_io_flow: assert property (@(posedge clk) disable iff (reset) io_valid |-> io_available)
		else $error("IO request enqueued while io_available is low");

endmodule

/* source/request_fifo.sv */
// Synchronous FIFO with empty and almost-full flags, used for the IO request and response queues
`timescale 1ns/1ps

module request_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8,
	parameter int ALMOST_FULL = DEPTH - 1
) (
	input logic clk,
	input logic reset,
	input logic enqueue,
	input logic [WIDTH-1:0] value_in,
	input logic dequeue,
	output logic [WIDTH-1:0] value_out,
	output logic empty,
	output logic almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	// Pointer advance with wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (enqueue)
			storage[wr_ptr] <= value_in;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (enqueue)
				wr_ptr <= next_ptr(wr_ptr);
			if (dequeue)
				rd_ptr <= next_ptr(rd_ptr);
			case ({enqueue, dequeue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry, valid from the cycle after its enqueue
	assign value_out = storage[rd_ptr];
	assign empty = (count == '0);
	assign almost_full = (count >= CNT_W'(ALMOST_FULL));

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		enqueue |-> (count != CNT_W'(DEPTH)) || dequeue)
		else $error("request_fifo enqueue while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (reset) dequeue |-> !empty)
		else $error("request_fifo dequeue while empty");

endmodule

/* source/cc_pkg.sv */
// Shared types of the cache controller, referenced with cc_pkg:: scoped names
`include "cc_defs.svh"

package cc_pkg;

	// Byte address, tag in the top bits and set index above the line offset
	typedef logic [`CC_ADDR_W-1:0] address_t;
	typedef logic [`CC_TAG_W-1:0] tag_t;
	typedef logic [`CC_INDEX_W-1:0] set_t;
	typedef logic [$clog2(`CC_WAYS)-1:0] way_idx_t;
	typedef logic [`CC_WAYS-1:0] way_mask_t;

	typedef logic [`CC_LINE_W-1:0] line_t;
	// One bit per byte of a line
	typedef logic [`CC_LINE_W/8-1:0] dirty_mask_t;

	typedef logic [$clog2(`CC_THREADS)-1:0] thread_id_t;
	typedef logic [`CC_REG_W-1:0] reg_t;

	// Bit 1 is read, bit 0 is write, both clear means the way is invalid
	typedef logic [1:0] privileges_t;

	// 1 is a write, 0 a read
	typedef logic io_op_t;

	typedef struct packed {
		thread_id_t thread;
		io_op_t op;
		address_t address;
		reg_t data;
	} io_entry_t;

	typedef enum logic {
		CC_UPDATE_INFO_DATA,
		CC_REPLACEMENT
	} cc_command_t;

	typedef enum logic [1:0] {
		IDLE,
		SEND_REQ,
		WAIT_RESP
	} cc_state_t;

endpackage

/* source/cc_defs.svh */
// Widths, sizes and IO FIFO thresholds of the cache controller, included by every user
`ifndef CC_DEFS_SVH
`define CC_DEFS_SVH

// Address split into tag, set index and line offset
`define CC_ADDR_W 32
`define CC_OFFSET_W 6
`define CC_INDEX_W 5
`define CC_TAG_W 21

// Cache geometry
`define CC_LINE_W 512
`define CC_WAYS 4
`define CC_SETS 32

// Core side
`define CC_THREADS 4
`define CC_REG_W 32

// IO request and response buffering
`define CC_IO_FIFO_DEPTH 8
// Occupancy of the request FIFO at which new IO requests are refused
`define CC_IO_ALMOST_FULL 4

`endif
